/* hdl/opl_pkg.sv */
package opl_pkg;

    localparam int num_slots = 18;  // operators per round
    localparam int num_ch    = 9;

    // position of the active slot
    typedef struct packed {
        logic [1:0] group;
        logic [2:0] subslot;
        logic       op;             // carrier, subslots 3 to 5
    } slot_pos_t;

    typedef struct packed {
        logic       wr;
        logic       addr_phase;     // din carries an address
        logic [7:0] din;
    } host_wr_t;

    // views of one operator data byte
    typedef struct packed {
        logic       am;
        logic       vib;
        logic       egt;
        logic       ksr;
        logic [3:0] mult;
    } mult_reg_t;

    typedef struct packed {
        logic [1:0] ksl;
        logic [5:0] tl;
    } ksl_tl_t;

    typedef struct packed {
        logic [3:0] ar;
        logic [3:0] dr;
    } ar_dr_t;

    typedef struct packed {
        logic [3:0] sl;
        logic [3:0] rr;
    } sl_rr_t;

    typedef union packed {
        mult_reg_t mult;
        ksl_tl_t   ksl_tl;
        ar_dr_t    ar_dr;
        sl_rr_t    sl_rr;
    } op_reg_u;

    typedef struct packed {
        logic mult;
        logic ksl_tl;
        logic ar_dr;
        logic sl_rr;
        logic wav;
    } op_up_t;

    typedef struct packed {
        logic fnumlo;
        logic fnumhi;
        logic fbcon;
    } ch_up_t;

    // one channel, 18 bits
    typedef struct packed {
        logic       keyon;
        logic [2:0] block;
        logic [9:0] fnum;
        logic [2:0] fb;
        logic       con;
    } ch_cfg_t;

    // wav kept lowest so it can be dropped from storage
    typedef struct packed {
        logic       am;
        logic       vib;
        logic       en_sus;
        logic       ks;
        logic [3:0] mul;
        logic [1:0] ksl;
        logic [5:0] tl;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
        logic [1:0] wav;
    } op_cfg_t;

endpackage

/* hdl/opl_ch_delay.sv */
`timescale 1ns/10ps

module opl_ch_delay import opl_pkg::*; #(
    parameter int stages = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  ch_cfg_t din,
    output ch_cfg_t dout
);

    ch_cfg_t line [0:stages-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < stages; i++) begin
                line[i] <= '0;
            end
        end else if (cen) begin
            line[0] <= din;
            for (int i = 1; i < stages; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    assign dout = line[stages-1];

endmodule

/* hdl/opl_op_csr.sv */
`timescale 1ns/10ps

module opl_op_csr import opl_pkg::*; #(
    parameter int opl_type = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  op_reg_u dat,
    input  op_up_t  op_up,
    input  logic    update_I,
    input  logic    update_II,
    input  logic    update_IV,
    output op_cfg_t shift_out
);

    localparam int cfg_w = $bits(op_cfg_t);
    localparam int w     = (opl_type == 2) ? cfg_w : cfg_w - 2;  // no wav on type 1

    logic [num_slots-1:0][w-1:0] sr;
    logic [w-1:0]                word_in;
    op_cfg_t                     nxt;

    // each field is loaded when its own stage sees the addressed slot
    always_comb begin
        nxt = shift_out;
        if (update_I && op_up.mult) begin
            nxt.vib    = dat.mult.vib;
            nxt.en_sus = dat.mult.egt;
        end
        if (update_II && op_up.mult) begin
            nxt.ks  = dat.mult.ksr;
            nxt.mul = dat.mult.mult;
        end
        if (update_IV && op_up.mult) nxt.am = dat.mult.am;
        if (update_IV && op_up.ksl_tl) begin
            nxt.ksl = dat.ksl_tl.ksl;
            nxt.tl  = dat.ksl_tl.tl;
        end
        if (update_I && op_up.ar_dr) begin
            nxt.ar = dat.ar_dr.ar;
            nxt.dr = dat.ar_dr.dr;
        end
        if (update_I && op_up.sl_rr) begin
            nxt.sl = dat.sl_rr.sl;
            nxt.rr = dat.sl_rr.rr;
        end
        if (update_I && op_up.wav) nxt.wav = dat[1:0];
    end

    if (opl_type == 2) begin : g_wav
        assign word_in   = nxt;
        assign shift_out = sr[num_slots-1];
    end else begin : g_no_wav
        assign word_in   = nxt[cfg_w-1:2];
        assign shift_out = {sr[num_slots-1], 2'b00};   // wav reads 0
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sr <= '0;
        end else if (cen) begin
            sr <= {sr[num_slots-2:0], word_in};
        end
    end

endmodule

/* hdl/opl_reg_decode.sv */
`timescale 1ns/10ps

module opl_reg_decode import opl_pkg::*; #(
    parameter int opl_type = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  host_wr_t   host,
    input  logic       zero,
    output op_up_t     op_up,
    output ch_up_t     ch_up,
    output logic [1:0] sel_group,
    output logic [2:0] sel_sub,
    output op_reg_u    dat,
    output logic       write,
    output logic       rhy_en,
    output logic [4:0] rhy_kon,
    output logic       wave_mode
);

    logic [7:0] addr;
    logic       data_wr;
    logic       zcnt;       // first zero pulse seen
    op_up_t     op_hit;
    ch_up_t     ch_hit;
    logic [1:0] dec_group;
    logic [2:0] dec_sub;

    assign data_wr = host.wr && !host.addr_phase;

    always_comb begin
        logic       op_ok;
        logic       ch_ok;
        logic [3:0] ch_num;
        op_ok     = addr[4:3] != 2'd3 && addr[2:0] <= 3'd5;
        ch_num    = addr[3:0];
        ch_ok     = ch_num < num_ch;
        op_hit    = '0;
        ch_hit    = '0;
        dec_group = addr[4:3];
        dec_sub   = addr[2:0];
        case (addr[7:5])
            3'd1: op_hit.mult   = op_ok;
            3'd2: op_hit.ksl_tl = op_ok;
            3'd3: op_hit.ar_dr  = op_ok;
            3'd4: op_hit.sl_rr  = op_ok;
            3'd7: op_hit.wav    = op_ok && opl_type == 2;
            default: ;
        endcase
        case (addr[7:4])
            4'ha: ch_hit.fnumlo = ch_ok;
            4'hb: ch_hit.fnumhi = ch_ok;
            4'hc: ch_hit.fbcon  = ch_ok;
            default: ;
        endcase
        if (ch_hit != '0) begin
            // three channels per group
            dec_group = 2'(ch_num / 3);
            dec_sub   = 3'(ch_num % 3);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr      <= '0;
            op_up     <= '0;
            ch_up     <= '0;
            sel_group <= '0;
            sel_sub   <= '0;
            write     <= 1'b0;
            zcnt      <= 1'b0;
            rhy_en    <= 1'b0;
            rhy_kon   <= '0;
            wave_mode <= 1'b0;
        end else begin
            write <= data_wr;
            if (host.wr && host.addr_phase) addr <= host.din;
            if (data_wr) begin
                op_up     <= op_hit;
                ch_up     <= ch_hit;
                sel_group <= dec_group;
                sel_sub   <= dec_sub;
                zcnt      <= 1'b0;
                if (addr == 8'hbd) {rhy_en, rhy_kon} <= host.din[5:0];
                if (addr == 8'h01 && opl_type == 2) wave_mode <= host.din[5];
            end else if (cen && zero && (op_up != '0 || ch_up != '0)) begin
                // strobes drop on the second zero pulse
                zcnt <= !zcnt;
                if (zcnt) begin
                    op_up <= '0;
                    ch_up <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) dat <= host.din;
    end

endmodule

/* hdl/opl_reg.sv */
`timescale 1ns/10ps

module opl_reg import opl_pkg::*; #(
    parameter int opl_type = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  op_up_t     op_up,
    input  ch_up_t     ch_up,
    input  logic [1:0] sel_group,
    input  logic [2:0] sel_sub,
    input  op_reg_u    dat,
    input  logic       write,
    input  logic       rhy_en,
    input  logic [4:0] rhy_kon,
    input  logic       wave_mode,
    output slot_pos_t  pos,
    output logic       zero,
    output ch_cfg_t    ch_I,
    output op_cfg_t    op_cfg
);

    // rhythm key-on bit order in BDh
    localparam int bd = 4, sd = 3, tom = 2, tc = 1, hh = 0;

    logic [num_slots-1:0] slot;     // one hot
    logic [2:0]           next_sub;
    logic [1:0]           next_group;
    logic                 match;
    logic                 update_I, update_II, update_III, update_IV;
    op_cfg_t              op_word;
    ch_cfg_t              grp_in  [0:2];
    ch_cfg_t              grp_out [0:2];
    ch_cfg_t              ch_cur, ch_new;
    logic [5:0]           rhy_csr;
    logic                 rhy_oen;  // rhythm override live for group 2

    assign next_sub   = pos.subslot == 3'd5 ? 3'd0 : pos.subslot + 3'd1;
    assign next_group = pos.subslot != 3'd5 ? pos.group :
                        (pos.group == 2'd2 ? 2'd0 : pos.group + 2'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos  <= '0;
            slot <= {{(num_slots-1){1'b0}}, 1'b1};
        end else if (cen) begin
            pos.group   <= next_group;
            pos.subslot <= next_sub;
            pos.op      <= next_sub >= 3'd3;
            slot        <= {slot[num_slots-2:0], slot[num_slots-1]};
        end
    end

    assign zero = slot[0];

    assign match    = {pos.group, pos.subslot} == {sel_group, sel_sub};
    assign update_I = match && !write;

    // later stages of the same update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {update_II, update_III, update_IV} <= '0;
        end else if (write) begin
            {update_II, update_III, update_IV} <= '0;   // a new target drops the old flags
        end else if (cen) begin
            update_II  <= update_I;
            update_III <= update_II;
            update_IV  <= update_III;
        end
    end

    opl_op_csr #(.opl_type(opl_type)) u_op_csr (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .dat       (dat),
        .op_up     (op_up),
        .update_I  (update_I),
        .update_II (update_II),
        .update_IV (update_IV),
        .shift_out (op_word)
    );

    always_comb begin
        case (pos.group)
            2'd1:    ch_cur = grp_out[1];
            2'd2:    ch_cur = grp_out[2];
            default: ch_cur = grp_out[0];
        endcase
        ch_new = ch_cur;
        if (ch_up.fnumlo && match) ch_new.fnum[7:0] = dat;
        if (ch_up.fnumhi && match) {ch_new.keyon, ch_new.block, ch_new.fnum[9:8]} = dat[5:0];
        if (ch_up.fbcon && match) {ch_new.fb, ch_new.con} = dat[3:0];
    end

    for (genvar g = 0; g < 3; g++) begin : g_group
        assign grp_in[g] = pos.group == g ? ch_new : grp_out[g];

        opl_ch_delay #(.stages(3)) u_delay (
            .clk  (clk),
            .rst  (rst),
            .cen  (cen),
            .din  (grp_in[g]),
            .dout (grp_out[g])
        );
    end

    // key-on pattern of slots 12..17 for mod then carrier of ch 6..8
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rhy_csr <= '0;
            rhy_oen <= 1'b0;
        end else if (cen) begin
            if (slot[11]) rhy_oen <= rhy_en;
            if (slot[17]) begin
                rhy_csr <= {rhy_kon[bd], rhy_kon[hh], rhy_kon[tom],
                            rhy_kon[bd], rhy_kon[sd], rhy_kon[tc]};
                rhy_oen <= 1'b0;
            end else begin
                rhy_csr <= {rhy_csr[4:0], rhy_csr[5]};
            end
        end
    end

    always_comb begin
        ch_I = ch_cur;
        if (rhy_oen) ch_I.keyon = rhy_csr[5];
        if (rhy_oen && !slot[12] && !slot[13]) begin
            ch_I.con = 1'b1;    // percussion outputs add directly
        end
        op_cfg = op_word;
        if (rhy_oen) op_cfg.en_sus = 1'b0;
        op_cfg.wav = op_word.wav & {2{wave_mode}};
    end

endmodule

/* hdl/opl_top.sv */
`timescale 1ns/10ps

module opl_top import opl_pkg::*; #(
    parameter int opl_type = 1
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  host_wr_t  host,
    output slot_pos_t pos,
    output logic      zero,
    output ch_cfg_t   ch_I,
    output op_cfg_t   op_cfg
);

    op_up_t     op_up;
    ch_up_t     ch_up;
    logic [1:0] sel_group;
    logic [2:0] sel_sub;
    op_reg_u    dat;
    logic       write;
    logic       rhy_en;
    logic [4:0] rhy_kon;
    logic       wave_mode;

    opl_reg_decode #(.opl_type(opl_type)) u_decode (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .host      (host),
        .zero      (zero),
        .op_up     (op_up),
        .ch_up     (ch_up),
        .sel_group (sel_group),
        .sel_sub   (sel_sub),
        .dat       (dat),
        .write     (write),
        .rhy_en    (rhy_en),
        .rhy_kon   (rhy_kon),
        .wave_mode (wave_mode)
    );

    opl_reg #(.opl_type(opl_type)) u_reg (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op_up     (op_up),
        .ch_up     (ch_up),
        .sel_group (sel_group),
        .sel_sub   (sel_sub),
        .dat       (dat),
        .write     (write),
        .rhy_en    (rhy_en),
        .rhy_kon   (rhy_kon),
        .wave_mode (wave_mode),
        .pos       (pos),
        .zero      (zero),
        .ch_I      (ch_I),
        .op_cfg    (op_cfg)
    );

endmodule

/* verif/opl_tb.sv */
`timescale 1ns/10ps

module opl_tb import opl_pkg::*; ();

    // one write is address, sync to zero, data, two rounds and one checked round
    localparam int write_cycles = 2 + 2 * 18 + 3 + 2 * 36 + 2 * 18;
    localparam int num_writes   = 39;
    localparam int cycle_limit  = (8 + 2 + 2 * 72 + num_writes * write_cycles) * 3 / 2;

    logic      clk;
    logic      rst;
    logic      cen;
    host_wr_t  host;
    slot_pos_t pos;
    logic      zero;
    ch_cfg_t   ch_I;
    op_cfg_t   op_cfg;

    int          ref_slot;      // slot index the DUT should be showing
    int          cycles;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_bad;
    logic [31:0] lcg_state;

    // reference copy of the register file
    logic [7:0] r20 [num_slots];
    logic [7:0] r40 [num_slots];
    logic [7:0] r60 [num_slots];
    logic [7:0] r80 [num_slots];
    logic [7:0] re0 [num_slots];
    logic [7:0] ra [num_ch];
    logic [7:0] rb [num_ch];
    logic [7:0] rc [num_ch];
    logic [7:0] rbd;
    logic       wmode;

    opl_top #(.opl_type(2)) UUT (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .host   (host),
        .pos    (pos),
        .zero   (zero),
        .ch_I   (ch_I),
        .op_cfg (op_cfg)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            cen <= 1'b0;
        end else begin
            cen <= !cen;    // one slot step every second cycle
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ref_slot <= 0;
        end else if (cen) begin
            ref_slot <= (ref_slot == num_slots - 1) ? 0 : ref_slot + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    function automatic void model_write(input logic [7:0] a, input logic [7:0] d);
        int s;
        int c;
        s = int'(a[4:3]) * 6 + int'(a[2:0]);
        c = int'(a[3:0]);
        if (a == 8'hbd) begin
            rbd = d;
        end else if (a == 8'h01) begin
            wmode = d[5];
        end else if (a[7:4] >= 4'ha && a[7:4] <= 4'hc) begin
            if (c < num_ch) begin
                case (a[7:4])
                    4'ha:    ra[c] = d;
                    4'hb:    rb[c] = d;
                    default: rc[c] = d;
                endcase
            end
        end else if (a[4:3] != 2'd3 && a[2:0] <= 3'd5) begin
            case (a[7:5])
                3'd1: r20[s] = d;
                3'd2: r40[s] = d;
                3'd3: r60[s] = d;
                3'd4: r80[s] = d;
                3'd7: re0[s] = d;
                default: ;
            endcase
        end
    endfunction

    // _II fields lag one slot, _IV fields three
    function automatic op_cfg_t exp_op(input int s);
        op_cfg_t o;
        int      p1;
        int      p3;
        p1       = (s + num_slots - 1) % num_slots;
        p3       = (s + num_slots - 3) % num_slots;
        o.am     = r20[p3][7];
        o.vib    = r20[s][6];
        o.en_sus = r20[s][5] && !(rbd[5] && s >= 12);
        o.ks     = r20[p1][4];
        o.mul    = r20[p1][3:0];
        o.ksl    = r40[p3][7:6];
        o.tl     = r40[p3][5:0];
        o.ar     = r60[s][7:4];
        o.dr     = r60[s][3:0];
        o.sl     = r80[s][7:4];
        o.rr     = r80[s][3:0];
        o.wav    = wmode ? re0[s][1:0] : 2'b00;
        return o;
    endfunction

    function automatic ch_cfg_t exp_ch(input int s);
        ch_cfg_t h;
        int      c;
        int      kb;
        c       = (s / 6) * 3 + (s % 6) % 3;
        h.keyon = rb[c][5];
        h.block = rb[c][4:2];
        h.fnum  = {rb[c][1:0], ra[c]};
        h.fb    = rc[c][3:1];
        h.con   = rc[c][0];
        if (rbd[5] && s >= 12) begin
            case (s)
                12, 15:  kb = 4;    // bass drum on both ops of ch 6
                13:      kb = 0;    // hi-hat
                14:      kb = 2;    // tom
                16:      kb = 3;    // snare
                default: kb = 1;    // cymbal
            endcase
            h.keyon = rbd[kb];
            if (s >= 14) h.con = 1'b1;
        end
        return h;
    endfunction

    task automatic next_step();
        @(negedge clk);
        while (cen !== 1'b1) @(negedge clk);
    endtask

    task automatic wait_zero();
        next_step();
        while (ref_slot != 0) next_step();
    endtask

    task automatic check_round();
        op_cfg_t want_op;
        ch_cfg_t want_ch;
        for (int i = 0; i < num_slots; i++) begin
            next_step();
            want_op = exp_op(ref_slot);
            want_ch = exp_ch(ref_slot);
            checks += 2;
            assert (op_cfg == want_op) else begin
                errors++;
                $display("Fail op_cfg slot %0d: got %h, expected %h", ref_slot, op_cfg, want_op);
            end
            assert (ch_I == want_ch) else begin
                errors++;
                $display("Fail ch_I slot %0d: got %h, expected %h", ref_slot, ch_I, want_ch);
            end
        end
    endtask

    // data lands just after slot 1, so the write cycle carries no cen
    task automatic write_and_check(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        host <= '{wr: 1'b1, addr_phase: 1'b1, din: a};
        @(posedge clk);
        host <= '0;
        wait_zero();
        @(posedge clk);
        @(posedge clk);
        host <= '{wr: 1'b1, addr_phase: 1'b0, din: d};
        @(posedge clk);
        host <= '0;
        model_write(a, d);
        repeat (2 * num_slots) next_step();
        check_round();
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    initial begin
        logic [7:0] fam [4];
        logic [7:0] g;
        logic [7:0] sub;
        slot_pos_t  want_pos;
        int         mark;
        fam       = '{8'h20, 8'h40, 8'h60, 8'h80};
        clk       = 1'b0;
        rst       = 1'b1;
        cen       = 1'b0;
        host      = '0;
        cycles    = 0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        tests_bad = 0;
        lcg_state = 32'h293b1a1f;
        rbd       = '0;
        wmode     = 1'b0;
        for (int i = 0; i < num_slots; i++) begin
            r20[i] = '0;
            r40[i] = '0;
            r60[i] = '0;
            r80[i] = '0;
            re0[i] = '0;
        end
        for (int i = 0; i < num_ch; i++) begin
            ra[i] = '0;
            rb[i] = '0;
            rc[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        mark = errors;
        next_step();
        checks += 3;
        assert (zero === 1'b1 && pos === '0) else begin
            errors++;
            $display("Fail zero/pos: got %h/%h, expected 1/00", zero, pos);
        end
        assert (ch_I.keyon === 1'b0 && ch_I.fnum === '0) else begin
            errors++;
            $display("Fail ch_I.keyon/fnum: got %h/%h, expected 0/000", ch_I.keyon, ch_I.fnum);
        end
        assert (op_cfg.tl === '0) else begin
            errors++;
            $display("Fail op_cfg.tl: got %h, expected 00", op_cfg.tl);
        end
        end_test("reset state", mark);

        mark = errors;
        wait_zero();
        for (int i = 0; i < 3 * num_slots; i++) begin
            want_pos.group   = 2'(ref_slot / 6);
            want_pos.subslot = 3'(ref_slot % 6);
            want_pos.op      = (ref_slot % 6) >= 3;
            checks += 2;
            assert (zero === (ref_slot == 0)) else begin
                errors++;
                $display("Fail zero at slot %0d: got %h, expected %h",
                         ref_slot, zero, ref_slot == 0);
            end
            assert (pos === want_pos) else begin
                errors++;
                $display("Fail pos: got %h, expected %h", pos, want_pos);
            end
            next_step();
        end
        end_test("slot counter", mark);

        mark = errors;
        for (int i = 0; i < 16; i++) begin
            g   = rand_byte() % 8'd3;
            sub = rand_byte() % 8'd6;
            write_and_check(fam[i % 4] + g * 8'd8 + sub, rand_byte());
        end
        end_test("operator writes", mark);

        mark = errors;
        for (int i = 0; i < 4; i++) begin
            g = rand_byte() % 8'd9;     // channel number
            write_and_check(8'ha0 + g, rand_byte());
            write_and_check(8'hb0 + g, rand_byte());
            write_and_check(8'hc0 + g, rand_byte());
        end
        end_test("channel writes", mark);

        mark = errors;
        write_and_check(8'hc8, 8'h00);  // con low on ch 8
        write_and_check(8'h32, 8'h2f);  // egt set at slot 14
        for (int i = 0; i < 3; i++) begin
            write_and_check(8'hbd, 8'h20 | (rand_byte() & 8'h1f));
        end
        write_and_check(8'hbd, 8'h00);
        end_test("rhythm mode", mark);

        mark = errors;
        write_and_check(8'h01, 8'h20);
        for (int i = 0; i < 3; i++) begin
            g   = rand_byte() % 8'd3;
            sub = rand_byte() % 8'd6;
            write_and_check(8'he0 + g * 8'd8 + sub, rand_byte());
        end
        write_and_check(8'h01, 8'h00);
        end_test("wave select", mark);

        $display("%0d tests run, %0d with errors, %0d checks, %0d mismatches",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/opl_pkg.sv
hdl/opl_ch_delay.sv
hdl/opl_op_csr.sv
hdl/opl_reg_decode.sv
hdl/opl_reg.sv
hdl/opl_top.sv
verif/opl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the OPL register front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module opl_tb -o opl_sim
./obj_dir/opl_sim | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation clean"
